// ==== Bender.yml ====
package:
  name: dbg_subsys

sources:
  - include_dirs:
      - src
    files:
      - src/jtag_pkg.sv
      - src/dm_pkg.sv
      - src/jtag_dtm.sv
      - src/dm_regs.sv
      - src/sys_sram.sv
      - src/hart_stub.sv
      - src/dbg_top.sv
  - target: test
    include_dirs:
      - src
      - verif
    files:
      - verif/tb_dbg_top.sv

// ==== build.f ====
+incdir+src
+incdir+verif
src/jtag_pkg.sv
src/dm_pkg.sv
src/jtag_dtm.sv
src/dm_regs.sv
src/sys_sram.sv
src/hart_stub.sv
src/dbg_top.sv
verif/tb_dbg_top.sv

// ==== src/dbg_consts.svh ====
// debug subsystem constants
// jtag identity, dmi geometry, sram depth and hart boot address

`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// jtag identification code, lsb is always one
`define DBG_IDCODE 32'h1000_0DB3

// instruction register length of the tap
`define DBG_IR_LEN 5

// dmi address width, also reported in dtmcs.abits
`define DBG_DMI_AW 7

// system sram depth in 32-bit words
`define DBG_SRAM_WORDS 256

// hart pc out of reset
`define DBG_BOOT_ADDR 32'h0000_8000

`endif

// ==== src/dbg_top.sv ====
// debug subsystem top
// jtag dtm, debug module, system sram and hart stub
`timescale 1ns/1ns
`include "dbg_consts.svh"

module dbg_top import dm_pkg::*; (
   input  logic        clk_sys,
   input  logic        arst_n_i,
   input  logic        trst_n_i,
   input  logic        tms_i,
   input  logic        tdi_i,
   output logic        tdo_o,
   output logic        hart_halted_o,
   output logic [31:0] hart_pc_o
);

   // dtm to debug module
   logic                   dmi_req;
   dmi_op_e                dmi_op;
   logic [`DBG_DMI_AW-1:0] dmi_addr;
   logic [31:0]            dmi_wdata;
   logic [31:0]            dmi_rdata;
   // debug module to sram
   logic                   bus_req;
   logic                   bus_we;
   logic [31:0]            bus_addr;
   logic [31:0]            bus_wdata;
   logic [31:0]            bus_rdata;
   // debug module to hart
   logic                   halt_req;
   logic                   resume_req;
   logic                   dpc_we;
   logic [31:0]            dpc_wdata;

   // tck is clk_sys
   jtag_dtm u_jtag_dtm (
      .clk_sys     (clk_sys),
      .arst_n_i    (arst_n_i),
      .trst_n_i    (trst_n_i),
      .tms_i       (tms_i),
      .tdi_i       (tdi_i),
      .tdo_o       (tdo_o),
      .dmi_req_o   (dmi_req),
      .dmi_op_o    (dmi_op),
      .dmi_addr_o  (dmi_addr),
      .dmi_wdata_o (dmi_wdata),
      .dmi_rdata_i (dmi_rdata)
   );

   dm_regs u_dm_regs (
      .clk_sys      (clk_sys),
      .arst_n_i     (arst_n_i),
      .dmi_req_i    (dmi_req),
      .dmi_op_i     (dmi_op),
      .dmi_addr_i   (dmi_addr),
      .dmi_wdata_i  (dmi_wdata),
      .dmi_rdata_o  (dmi_rdata),
      .bus_req_o    (bus_req),
      .bus_we_o     (bus_we),
      .bus_addr_o   (bus_addr),
      .bus_wdata_o  (bus_wdata),
      .bus_rdata_i  (bus_rdata),
      .halt_req_o   (halt_req),
      .resume_req_o (resume_req),
      .dpc_we_o     (dpc_we),
      .dpc_wdata_o  (dpc_wdata),
      .halted_i     (hart_halted_o)
   );

   sys_sram u_sys_sram (
      .clk_sys     (clk_sys),
      .bus_req_i   (bus_req),
      .bus_we_i    (bus_we),
      .bus_addr_i  (bus_addr),
      .bus_wdata_i (bus_wdata),
      .bus_rdata_o (bus_rdata)
   );

   hart_stub u_hart_stub (
      .clk_sys      (clk_sys),
      .arst_n_i     (arst_n_i),
      .halt_req_i   (halt_req),
      .resume_req_i (resume_req),
      .dpc_we_i     (dpc_we),
      .dpc_wdata_i  (dpc_wdata),
      .halted_o     (hart_halted_o),
      .pc_o         (hart_pc_o)
   );

endmodule

// ==== src/dm_pkg.sv ====
// debug module types
// dmi ops, register map, sbcs layout and dpc register number
`include "dbg_consts.svh"

package dm_pkg;

   // op field of a dmi scan
   typedef enum logic [1:0] {
      DMI_NOP   = 2'h0,
      DMI_READ  = 2'h1,
      DMI_WRITE = 2'h2
   } dmi_op_e;

   // debug module register addresses
   localparam logic [`DBG_DMI_AW-1:0] DATA0      = 'h04;
   localparam logic [`DBG_DMI_AW-1:0] DMCONTROL  = 'h10;
   localparam logic [`DBG_DMI_AW-1:0] DMSTATUS   = 'h11;
   localparam logic [`DBG_DMI_AW-1:0] COMMAND    = 'h17;
   localparam logic [`DBG_DMI_AW-1:0] SBCS       = 'h38;
   localparam logic [`DBG_DMI_AW-1:0] SBADDRESS0 = 'h39;
   localparam logic [`DBG_DMI_AW-1:0] SBDATA0    = 'h3C;

   // abstract command regno of the debug pc
   localparam logic [15:0] CSR_DPC = 16'h07B1;

   // sbcs bit layout as in the debug spec
   // only the fields this module implements, rest reads zero
   typedef struct packed {
      logic [9:0]  rsvd_hi;
      logic        sbbusy;
      logic        sbreadonaddr;
      logic [2:0]  sbaccess;
      logic        sbautoincrement;
      logic        sbreadondata;
      logic [14:0] rsvd_lo;
   } sbcs_t;

   // one dmi data word, raw or as sbcs fields
   typedef union packed {
      logic [31:0] raw;
      sbcs_t       sbcs;
   } dm_word_u;

endpackage

// ==== src/dm_regs.sv ====
// debug module register file
// dmi decode, system bus master, halt/resume and dpc abstract command
`timescale 1ns/1ns
`include "dbg_consts.svh"

module dm_regs import dm_pkg::*; (
   input  logic                   clk_sys,
   input  logic                   arst_n_i,
   // dmi side
   input  logic                   dmi_req_i,
   input  dmi_op_e                dmi_op_i,
   input  logic [`DBG_DMI_AW-1:0] dmi_addr_i,
   input  logic [31:0]            dmi_wdata_i,
   output logic [31:0]            dmi_rdata_o,
   // system bus side
   output logic                   bus_req_o,
   output logic                   bus_we_o,
   output logic [31:0]            bus_addr_o,
   output logic [31:0]            bus_wdata_o,
   input  logic [31:0]            bus_rdata_i,
   // hart side
   output logic                   halt_req_o,
   output logic                   resume_req_o,
   output logic                   dpc_we_o,
   output logic [31:0]            dpc_wdata_o,
   input  logic                   halted_i
);

   // system bus sequencer states
   localparam logic [1:0] SB_IDLE    = 2'd0;
   localparam logic [1:0] SB_WR      = 2'd1;
   localparam logic [1:0] SB_RD_REQ  = 2'd2;
   localparam logic [1:0] SB_RD_DATA = 2'd3;

   logic        dmactive_q;
   logic [31:0] data0_q;
   dm_word_u    sbcs_q;
   dm_word_u    sbcs_rd;
   logic [31:0] sbaddress_q;
   logic [31:0] sbdata_q;
   logic [1:0]  sb_state_q;
   logic        sb_busy;
   logic        sb_access;
   logic        sb_write_go;
   logic        sb_read_go;
   logic        sb_done;
   logic        dmi_wr;
   logic        dmi_rd;
   logic        cmd_dpc_write;
   logic [31:0] dmstatus;
   logic [31:0] rdata_mux;

   assign dmi_wr = dmi_req_i && (dmi_op_i == DMI_WRITE);
   assign dmi_rd = dmi_req_i && (dmi_op_i == DMI_READ);

   assign sb_busy   = (sb_state_q != SB_IDLE);
   // sb registers are frozen while a bus access runs
   assign sb_access = dmactive_q && !sb_busy;
   assign sb_done   = (sb_state_q == SB_WR) || (sb_state_q == SB_RD_DATA);

   assign sb_write_go = sb_access && dmi_wr && (dmi_addr_i == SBDATA0);
   assign sb_read_go  = sb_access &&
                        ((dmi_wr && (dmi_addr_i == SBADDRESS0) && sbcs_q.sbcs.sbreadonaddr) ||
                         (dmi_rd && (dmi_addr_i == SBDATA0) && sbcs_q.sbcs.sbreadondata));

   // access register command: cmdtype 0, transfer, write, regno dpc
   assign cmd_dpc_write = dmi_wr && (dmi_addr_i == COMMAND) && dmactive_q && halted_i &&
                          (dmi_wdata_i[31:24] == 8'h00) && dmi_wdata_i[17] &&
                          dmi_wdata_i[16] && (dmi_wdata_i[15:0] == CSR_DPC);

   // bus strobes come straight from the sequencer state
   assign bus_req_o   = (sb_state_q == SB_WR) || (sb_state_q == SB_RD_REQ);
   assign bus_we_o    = (sb_state_q == SB_WR);
   assign bus_addr_o  = sbaddress_q;
   assign bus_wdata_o = sbdata_q;
   assign dpc_wdata_o = data0_q;

   // version 0.13, authenticated, any/all halted and running
   assign dmstatus = {20'b0, ~halted_i, ~halted_i, halted_i, halted_i, 1'b1, 3'b0, 4'd2};

   always_comb begin
      sbcs_rd             = sbcs_q;
      sbcs_rd.sbcs.sbbusy = sb_busy;
      case (dmi_addr_i)
         DATA0:      rdata_mux = data0_q;
         DMCONTROL:  rdata_mux = {31'b0, dmactive_q};
         DMSTATUS:   rdata_mux = dmstatus;
         SBCS:       rdata_mux = sbcs_rd.raw;
         SBADDRESS0: rdata_mux = sbaddress_q;
         SBDATA0:    rdata_mux = sbdata_q;
         default:    rdata_mux = '0;
      endcase
   end

   // control state and hart strobes
   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dmactive_q   <= 1'b0;
         sbcs_q       <= '0;
         sb_state_q   <= SB_IDLE;
         halt_req_o   <= 1'b0;
         resume_req_o <= 1'b0;
         dpc_we_o     <= 1'b0;
      end else begin
         halt_req_o   <= 1'b0;
         resume_req_o <= 1'b0;
         dpc_we_o     <= cmd_dpc_write;
         if (dmi_wr && (dmi_addr_i == DMCONTROL)) begin
            dmactive_q   <= dmi_wdata_i[0];
            halt_req_o   <= dmactive_q && dmi_wdata_i[31];
            // haltreq wins over resumereq
            resume_req_o <= dmactive_q && dmi_wdata_i[30] && !dmi_wdata_i[31];
         end
         if (sb_access && dmi_wr && (dmi_addr_i == SBCS)) begin
            sbcs_q.raw          <= dmi_wdata_i;
            // unimplemented and status bits stay zero
            sbcs_q.sbcs.rsvd_hi <= '0;
            sbcs_q.sbcs.sbbusy  <= 1'b0;
            sbcs_q.sbcs.rsvd_lo <= '0;
         end
         case (sb_state_q)
            SB_IDLE: begin
               if (sb_write_go) begin
                  sb_state_q <= SB_WR;
               end else if (sb_read_go) begin
                  sb_state_q <= SB_RD_REQ;
               end
            end
            SB_RD_REQ: sb_state_q <= SB_RD_DATA;
            default:   sb_state_q <= SB_IDLE;
         endcase
      end
   end

   // payload registers
   always_ff @(posedge clk_sys) begin
      if (dmactive_q && dmi_wr && (dmi_addr_i == DATA0)) begin
         data0_q <= dmi_wdata_i;
      end
      if (sb_access && dmi_wr && (dmi_addr_i == SBADDRESS0)) begin
         sbaddress_q <= dmi_wdata_i;
      end else if (sb_done && sbcs_q.sbcs.sbautoincrement) begin
         // one word per access
         sbaddress_q <= sbaddress_q + 32'd4;
      end
      if (sb_write_go) begin
         sbdata_q <= dmi_wdata_i;
      end else if (sb_state_q == SB_RD_DATA) begin
         sbdata_q <= bus_rdata_i;
      end
      // read data is sampled before a readondata fetch replaces it
      if (dmi_rd) begin
         dmi_rdata_o <= rdata_mux;
      end
   end

endmodule

// ==== src/hart_stub.sv ====
// minimal hart model
// counts its pc while running, halts into dpc and resumes from it
`timescale 1ns/1ns
`include "dbg_consts.svh"

module hart_stub (
   input  logic        clk_sys,
   input  logic        arst_n_i,
   input  logic        halt_req_i,
   input  logic        resume_req_i,
   input  logic        dpc_we_i,
   input  logic [31:0] dpc_wdata_i,
   output logic        halted_o,
   output logic [31:0] pc_o
);

   logic [31:0] dpc_q;

   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i) begin
         halted_o <= 1'b0;
         pc_o     <= `DBG_BOOT_ADDR;
         dpc_q    <= `DBG_BOOT_ADDR;
      end else begin
         if (!halted_o) begin
            if (halt_req_i) begin
               // enter debug mode, remember where we stopped
               halted_o <= 1'b1;
               dpc_q    <= pc_o;
            end else begin
               // one instruction per cycle
               pc_o <= pc_o + 32'd4;
            end
         end else begin
            if (resume_req_i) begin
               halted_o <= 1'b0;
               pc_o     <= dpc_q;
            end
            // debugger write of dpc while halted
            if (dpc_we_i) begin
               dpc_q <= dpc_wdata_i;
            end
         end
      end
   end

endmodule

// ==== src/jtag_dtm.sv ====
// jtag debug transport module
// tap controller with idcode, dtmcs, bypass and dmi registers, issues dmi requests
`timescale 1ns/1ns
`include "dbg_consts.svh"

module jtag_dtm import jtag_pkg::*; import dm_pkg::*; (
   input  logic                   clk_sys,
   input  logic                   arst_n_i,
   input  logic                   trst_n_i,
   input  logic                   tms_i,
   input  logic                   tdi_i,
   output logic                   tdo_o,
   output logic                   dmi_req_o,
   output dmi_op_e                dmi_op_o,
   output logic [`DBG_DMI_AW-1:0] dmi_addr_o,
   output logic [31:0]            dmi_wdata_o,
   input  logic [31:0]            dmi_rdata_i
);

   // dmi scan is {addr, data, op}
   localparam int DMI_W = `DBG_DMI_AW + 34;
   // dtmcs: idle hint 1, dmistat 0, abits, version 0.13
   localparam logic [31:0] DTMCS_VAL = {17'b0, 3'd1, 2'b0, 6'(`DBG_DMI_AW), 4'd1};

   logic                   tap_rst_n;
   tap_state_e             state_q;
   tap_state_e             state_d;
   ir_e                    ir_q;
   logic [`DBG_IR_LEN-1:0] ir_sr;
   logic [31:0]            sr32;
   logic                   bypass_q;
   logic [DMI_W-1:0]       dmi_sr;
   logic                   dmi_update;

   // either reset puts the tap back in test-logic-reset
   assign tap_rst_n = arst_n_i & trst_n_i;
   assign dmi_update = (state_q == TAP_UPD_DR) && (ir_q == IR_DMI);

   // tap next state, one step per tck edge
   always_comb begin
      case (state_q)
         TAP_RESET:    state_d = tms_i ? TAP_RESET    : TAP_IDLE;
         TAP_IDLE:     state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
         TAP_SEL_DR:   state_d = tms_i ? TAP_SEL_IR   : TAP_CAP_DR;
         TAP_CAP_DR:   state_d = tms_i ? TAP_EX1_DR   : TAP_SH_DR;
         TAP_SH_DR:    state_d = tms_i ? TAP_EX1_DR   : TAP_SH_DR;
         TAP_EX1_DR:   state_d = tms_i ? TAP_UPD_DR   : TAP_PAUSE_DR;
         TAP_PAUSE_DR: state_d = tms_i ? TAP_EX2_DR   : TAP_PAUSE_DR;
         TAP_EX2_DR:   state_d = tms_i ? TAP_UPD_DR   : TAP_SH_DR;
         TAP_UPD_DR:   state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
         TAP_SEL_IR:   state_d = tms_i ? TAP_RESET    : TAP_CAP_IR;
         TAP_CAP_IR:   state_d = tms_i ? TAP_EX1_IR   : TAP_SH_IR;
         TAP_SH_IR:    state_d = tms_i ? TAP_EX1_IR   : TAP_SH_IR;
         TAP_EX1_IR:   state_d = tms_i ? TAP_UPD_IR   : TAP_PAUSE_IR;
         TAP_PAUSE_IR: state_d = tms_i ? TAP_EX2_IR   : TAP_PAUSE_IR;
         TAP_EX2_IR:   state_d = tms_i ? TAP_UPD_IR   : TAP_SH_IR;
         TAP_UPD_IR:   state_d = tms_i ? TAP_SEL_DR   : TAP_IDLE;
         default:      state_d = TAP_RESET;
      endcase
   end

   // tap state and instruction register
   always_ff @(posedge clk_sys or negedge tap_rst_n) begin
      if (!tap_rst_n) begin
         state_q <= TAP_RESET;
         ir_q    <= IR_IDCODE;
         ir_sr   <= '0;
      end else begin
         state_q <= state_d;
         case (state_q)
            TAP_RESET:  ir_q  <= IR_IDCODE;
            // capture pattern 0..01 per 1149.1
            TAP_CAP_IR: ir_sr <= `DBG_IR_LEN'(1);
            TAP_SH_IR:  ir_sr <= {tdi_i, ir_sr[`DBG_IR_LEN-1:1]};
            TAP_UPD_IR: ir_q  <= ir_e'(ir_sr);
            default: ;
         endcase
      end
   end

   // data registers, lsb first
   always_ff @(posedge clk_sys) begin
      if (state_q == TAP_CAP_DR) begin
         sr32     <= (ir_q == IR_DTMCS) ? DTMCS_VAL : `DBG_IDCODE;
         bypass_q <= 1'b0;
         // last address, last read data, op status ok
         dmi_sr   <= {dmi_addr_o, dmi_rdata_i, 2'b00};
      end else if (state_q == TAP_SH_DR) begin
         case (ir_q)
            IR_IDCODE, IR_DTMCS: sr32   <= {tdi_i, sr32[31:1]};
            IR_DMI:              dmi_sr <= {tdi_i, dmi_sr[DMI_W-1:1]};
            default:             bypass_q <= tdi_i;
         endcase
      end
      if (dmi_update) begin
         dmi_wdata_o <= dmi_sr[33:2];
      end
   end

   // dmi request, one cycle after update-dr
   always_ff @(posedge clk_sys or negedge tap_rst_n) begin
      if (!tap_rst_n) begin
         dmi_req_o  <= 1'b0;
         dmi_op_o   <= DMI_NOP;
         dmi_addr_o <= '0;
      end else begin
         dmi_req_o <= 1'b0;
         if (dmi_update) begin
            dmi_addr_o <= dmi_sr[DMI_W-1 -: `DBG_DMI_AW];
            dmi_op_o   <= dmi_op_e'(dmi_sr[1:0]);
            // nop scans only fetch the captured data
            dmi_req_o  <= (dmi_sr[1:0] != 2'b00);
         end
      end
   end

   // tdo follows the shifted-out bit one cycle later
   always_ff @(posedge clk_sys or negedge tap_rst_n) begin
      if (!tap_rst_n) begin
         tdo_o <= 1'b0;
      end else begin
         case (state_q)
            TAP_SH_IR: tdo_o <= ir_sr[0];
            TAP_SH_DR: begin
               case (ir_q)
                  IR_IDCODE, IR_DTMCS: tdo_o <= sr32[0];
                  IR_DMI:              tdo_o <= dmi_sr[0];
                  default:             tdo_o <= bypass_q;
               endcase
            end
            default: tdo_o <= 1'b0;
         endcase
      end
   end

endmodule

// ==== src/jtag_pkg.sv ====
// jtag tap types
// tap state encoding and instruction codes
`include "dbg_consts.svh"

package jtag_pkg;

   // ieee 1149.1 state encoding
   typedef enum logic [3:0] {
      TAP_EX2_DR   = 4'h0,
      TAP_EX1_DR   = 4'h1,
      TAP_SH_DR    = 4'h2,
      TAP_PAUSE_DR = 4'h3,
      TAP_SEL_IR   = 4'h4,
      TAP_UPD_DR   = 4'h5,
      TAP_CAP_DR   = 4'h6,
      TAP_SEL_DR   = 4'h7,
      TAP_EX2_IR   = 4'h8,
      TAP_EX1_IR   = 4'h9,
      TAP_SH_IR    = 4'hA,
      TAP_PAUSE_IR = 4'hB,
      TAP_IDLE     = 4'hC,
      TAP_UPD_IR   = 4'hD,
      TAP_CAP_IR   = 4'hE,
      TAP_RESET    = 4'hF
   } tap_state_e;

   // riscv debug dtm instructions, anything else acts as bypass
   typedef enum logic [`DBG_IR_LEN-1:0] {
      IR_IDCODE = 'h01,
      IR_DTMCS  = 'h10,
      IR_DMI    = 'h11,
      IR_BYPASS = 'h1F
   } ir_e;

endpackage

// ==== src/sys_sram.sv ====
// system sram, single port, word wide
// byte address in, one word per request, read data one cycle later
`timescale 1ns/1ns
`include "dbg_consts.svh"

module sys_sram (
   input  logic        clk_sys,
   input  logic        bus_req_i,
   input  logic        bus_we_i,
   input  logic [31:0] bus_addr_i,
   input  logic [31:0] bus_wdata_i,
   output logic [31:0] bus_rdata_o
);

   // word index width
   localparam int IDX_W = $clog2(`DBG_SRAM_WORDS);

   logic [31:0]      mem_q [0:`DBG_SRAM_WORDS-1];
   logic [IDX_W-1:0] word_idx;

   // byte address to word index, upper bits wrap
   assign word_idx = bus_addr_i[IDX_W+1:2];

   always_ff @(posedge clk_sys) begin
      if (bus_req_i) begin
         if (bus_we_i) begin
            // full word writes only
            mem_q[word_idx] <= bus_wdata_i;
         end else begin
            // registered read port
            bus_rdata_o <= mem_q[word_idx];
         end
      end
   end

endmodule

// ==== verif/tb_dbg_tasks.svh ====
// jtag and dmi access tasks for the debug testbench
// tap stepping, ir and dr scans, debug module register access
`ifndef TB_DBG_TASKS_SVH
`define TB_DBG_TASKS_SVH

// one tck cycle, tdo sampled mid-cycle where it is stable
task automatic jtag_step(input logic tms, input logic tdi, output logic tdo);
   @(posedge clk_sys);
   tms_i <= tms;
   tdi_i <= tdi;
   @(negedge clk_sys);
   tdo = tdo_o;
endtask

// five tms highs reach test-logic-reset from any state, then idle
task automatic reset_tap();
   logic tdo;
   repeat (5) jtag_step(1'b1, 1'b0, tdo);
   jtag_step(1'b0, 1'b0, tdo);
endtask

// shift phase of a scan, lsb first, ends in run-test/idle
task automatic shift_bits(input int len, input logic [63:0] din, output logic [63:0] dout);
   logic tdo;
   dout = '0;
   for (int i = 0; i < len; i++) begin
      // last bit leaves shift with tms high
      jtag_step(i == len - 1, din[i], tdo);
      // tdo lags the shifted bit by one cycle
      if (i > 0) begin
         dout[i-1] = tdo;
      end
   end
   // exit1 to update
   jtag_step(1'b1, 1'b0, tdo);
   dout[len-1] = tdo;
   // update to idle
   jtag_step(1'b0, 1'b0, tdo);
endtask

// idle, select-dr, select-ir, capture-ir, then shift
task automatic scan_ir(input logic [`DBG_IR_LEN-1:0] ir,
                       output logic [`DBG_IR_LEN-1:0] captured);
   logic        tdo;
   logic [63:0] dout;
   jtag_step(1'b1, 1'b0, tdo);
   jtag_step(1'b1, 1'b0, tdo);
   jtag_step(1'b0, 1'b0, tdo);
   jtag_step(1'b0, 1'b0, tdo);
   shift_bits(`DBG_IR_LEN, 64'(ir), dout);
   captured = dout[`DBG_IR_LEN-1:0];
endtask

// idle, select-dr, capture-dr, then shift
task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
   logic tdo;
   jtag_step(1'b1, 1'b0, tdo);
   jtag_step(1'b0, 1'b0, tdo);
   jtag_step(1'b0, 1'b0, tdo);
   shift_bits(len, din, dout);
endtask

// dmi scan layout is {addr, data, op}
task automatic dmi_write(input logic [`DBG_DMI_AW-1:0] addr, input logic [31:0] data);
   logic [63:0] dout;
   scan_dr(DMI_LEN, 64'({addr, data, DMI_WRITE}), dout);
endtask

// read request, then a nop scan to fetch the captured data
task automatic dmi_read(input logic [`DBG_DMI_AW-1:0] addr, output logic [31:0] data);
   logic [63:0] dout;
   scan_dr(DMI_LEN, 64'({addr, 32'h0, DMI_READ}), dout);
   scan_dr(DMI_LEN, 64'({addr, 32'h0, DMI_NOP}), dout);
   check_true(dout[1:0] == 2'b00, "dmi read came back with a nonzero op status");
   data = dout[33:2];
endtask

// poll sbcs until the system bus is idle, a few tries at most
task automatic wait_sb_idle(input string who);
   logic [31:0] sbcs;
   int          tries;
   tries = 0;
   do begin
      dmi_read(SBCS, sbcs);
      tries++;
   end while (sbcs[SBBUSY_BIT] && tries < 8);
   check_true(!sbcs[SBBUSY_BIT], $sformatf("%s: sbbusy never cleared", who));
endtask

`endif

// ==== verif/tb_dbg_top.sv ====
// debug subsystem testbench
// directed jtag tests for sram preload, read-back, halt and resume
`timescale 1ns/1ns
`include "dbg_consts.svh"

module tb_dbg_top
   import jtag_pkg::*;
   import dm_pkg::*;
();

   // ~150 scans of ~50 cycles, with a margin of about eight
   localparam int TIMEOUT_CYCLES = 60000;
   localparam logic [31:0] SEED = 32'h2bcb_4f20;
   localparam int DMI_LEN = `DBG_DMI_AW + 34;
   // sbcs fields as in the debug spec
   localparam int SBBUSY_BIT = 21;
   localparam logic [31:0] SB_READONADDR = 32'h0010_0000;
   localparam logic [31:0] SB_ACCESS32   = 32'h0004_0000;
   localparam logic [31:0] SB_AUTOINC    = 32'h0001_0000;
   localparam logic [31:0] SB_READONDATA = 32'h0000_8000;
   // preload window and resume target
   localparam int NWORDS = 16;
   localparam logic [31:0] BASE_ADDR  = 32'h0000_0100;
   localparam logic [31:0] START_ADDR = 32'hF000_0080;

   logic        clk_sys;
   logic        arst_n_i;
   logic        trst_n_i;
   logic        tms_i;
   logic        tdi_i;
   logic        tdo_o;
   logic        hart_halted_o;
   logic [31:0] hart_pc_o;
   logic [31:0] ref_words [NWORDS];
   int          err_cnt = 0;
   int          check_cnt = 0;
   int          test_cnt = 0;
   int          cycle_cnt = 0;

   dbg_top u_dbg_top (
      .clk_sys       (clk_sys),
      .arst_n_i      (arst_n_i),
      .trst_n_i      (trst_n_i),
      .tms_i         (tms_i),
      .tdi_i         (tdi_i),
      .tdo_o         (tdo_o),
      .hart_halted_o (hart_halted_o),
      .hart_pc_o     (hart_pc_o)
   );

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      assert (act === exp) else begin
         $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      check_cnt++;
      assert (cond === 1'b1) else begin
         $display("ERROR %s", what);
         err_cnt++;
      end
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      test_cnt++;
      if (err_cnt == errs_at_start) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, err_cnt - errs_at_start);
      end
   endtask

   `include "tb_dbg_tasks.svh"

   task automatic check_idcode();
      int          errs;
      logic [63:0] dout;
      errs = err_cnt;
      // ir holds idcode after reset
      scan_dr(32, 64'h0, dout);
      check_word("idcode", `DBG_IDCODE, dout[31:0]);
      end_test("idcode", errs);
   endtask

   task automatic preload_sram();
      int                     errs;
      logic [`DBG_IR_LEN-1:0] ir_cap;
      logic [31:0]            rd;
      errs = err_cnt;
      // ir capture pattern is 0..01
      scan_ir(IR_DMI, ir_cap);
      check_word("sram preload ir capture", 32'h1, 32'(ir_cap));
      dmi_write(DMCONTROL, 32'h1);
      dmi_write(SBCS, SB_ACCESS32 | SB_AUTOINC);
      dmi_write(SBADDRESS0, BASE_ADDR);
      for (int i = 0; i < NWORDS; i++) begin
         ref_words[i] = $urandom();
         dmi_write(SBDATA0, ref_words[i]);
         wait_sb_idle("sram preload");
      end
      // one word step per write
      dmi_read(SBADDRESS0, rd);
      check_word("sram preload address", BASE_ADDR + 32'(4 * NWORDS), rd);
      end_test("sram preload", errs);
   endtask

   task automatic readback_sram();
      int          errs;
      logic [31:0] rd;
      errs = err_cnt;
      dmi_write(SBCS, SB_ACCESS32 | SB_AUTOINC | SB_READONADDR | SB_READONDATA);
      dmi_write(SBADDRESS0, BASE_ADDR);
      wait_sb_idle("sram readback");
      for (int i = 0; i < NWORDS; i++) begin
         dmi_read(SBDATA0, rd);
         check_word($sformatf("sram readback word %0d", i), ref_words[i], rd);
      end
      // address fetch plus one fetch per read
      dmi_read(SBADDRESS0, rd);
      check_word("sram readback address", BASE_ADDR + 32'(4 * (NWORDS + 1)), rd);
      end_test("sram readback", errs);
   endtask

   task automatic halt_hart();
      int          errs;
      int          tries;
      logic [31:0] rd;
      logic [31:0] pc_held;
      errs = err_cnt;
      @(negedge clk_sys);
      pc_held = hart_pc_o;
      check_true(pc_held > `DBG_BOOT_ADDR && ((pc_held - `DBG_BOOT_ADDR) % 4) == 0,
                 "hart pc did not advance from the boot address in word steps");
      dmi_write(DMCONTROL, 32'h8000_0001);
      tries = 0;
      do begin
         dmi_read(DMSTATUS, rd);
         tries++;
      end while (!rd[8] && tries < 10);
      check_true(rd[8], "dmstatus never reported the hart as halted");
      check_word("halt allhalted", 32'h1, 32'(rd[9]));
      check_word("halt output", 32'h1, 32'(hart_halted_o));
      pc_held = hart_pc_o;
      repeat (20) @(negedge clk_sys);
      check_word("halt pc held", pc_held, hart_pc_o);
      end_test("halt", errs);
   endtask

   task automatic resume_at_dpc();
      int          errs;
      int          tries;
      logic [31:0] pc;
      errs = err_cnt;
      dmi_write(DATA0, START_ADDR);
      // access register: aarsize 32, transfer, write, regno dpc
      dmi_write(COMMAND, 32'h0023_0000 | 32'(CSR_DPC));
      dmi_write(DMCONTROL, 32'h4000_0001);
      tries = 0;
      while (hart_halted_o && tries < 10) begin
         @(negedge clk_sys);
         tries++;
      end
      check_word("resume halted", 32'h0, 32'(hart_halted_o));
      // pc is loaded in the same cycle halted drops
      check_word("resume first pc", START_ADDR, hart_pc_o);
      repeat (5) @(negedge clk_sys);
      pc = hart_pc_o;
      check_true(pc >= START_ADDR && (pc - START_ADDR) <= 200 && pc[1:0] == 2'b00,
                 $sformatf("pc 0x%08h is not a word step within 200 bytes of 0x%08h",
                           pc, START_ADDR));
      dmi_write(DMCONTROL, 32'h0000_0001);
      check_word("resume still running", 32'h0, 32'(hart_halted_o));
      end_test("resume", errs);
   endtask

   task automatic inactive_dm_write();
      int          errs;
      logic [31:0] rd;
      errs = err_cnt;
      // park the bus address on the first preloaded word
      dmi_write(SBCS, SB_ACCESS32);
      dmi_write(SBADDRESS0, BASE_ADDR);
      dmi_write(DMCONTROL, 32'h0);
      dmi_write(SBDATA0, ~ref_words[0]);
      // reactivate and fetch the word again
      dmi_write(DMCONTROL, 32'h1);
      dmi_write(SBCS, SB_ACCESS32 | SB_READONADDR);
      dmi_write(SBADDRESS0, BASE_ADDR);
      wait_sb_idle("inactive module");
      dmi_read(SBDATA0, rd);
      check_word("inactive module word 0", ref_words[0], rd);
      end_test("inactive module", errs);
   endtask

   initial begin
      clk_sys = 1'b0;
      forever #50 clk_sys = ~clk_sys;
   end

   // hard stop if a test never returns
   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk_sys);
         cycle_cnt++;
      end
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      arst_n_i = 1'b0;
      trst_n_i = 1'b0;
      tms_i    = 1'b1;
      tdi_i    = 1'b0;
      void'($urandom(SEED));
      repeat (2) @(posedge clk_sys);
      arst_n_i <= 1'b1;
      trst_n_i <= 1'b1;
      reset_tap();
      check_idcode();
      preload_sram();
      readback_sram();
      halt_hart();
      resume_at_dpc();
      inactive_dm_write();
      $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
